// File: src.f
+incdir+.
decode_pkg.sv
decode_if.sv
instr_decoder.sv
reg_file.sv
issue_stage.sv
decode_stage.sv
tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/100ps -f src.f --top-module tb_decode_stage \
    && ./obj_dir/Vtb_decode_stage | tee sim.log \
    || echo "Build or run error"
grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_decode_stage.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int TIMEOUT = 50;                   // Cycles a wait may last.

    logic                   clk_i, rstn_i, instr_valid_i, credit_i;
    logic [`XLEN-1:0]       pc_i;
    instr_u                 instr_i;
    logic                   rd_we_i;
    logic [`REG_ADDR_W-1:0] rd_addr_i;
    logic [`XLEN-1:0]       rd_data_i;
    logic                   stall_o, valid_o, rf_we_o, mem_we_o;
    logic [`XLEN-1:0]       pc_o, instr_o, rs1_data_o, rs2_data_o, imm_o;
    operation_e             op_o;
    logic [`REG_ADDR_W-1:0] rd_addr_o;

    logic [31:0]      rng;                         // Xorshift state.
    logic [`XLEN-1:0] pc_next;                     // PC of the next issued instruction.
    logic [`XLEN-1:0] model_regs [`REG_COUNT];     // Expected register contents.
    int               errors, tests_run, tests_failed;

    decode_stage dut (
        .clk_i(clk_i), .rstn_i(rstn_i), .instr_valid_i(instr_valid_i), .credit_i(credit_i),
        .pc_i(pc_i), .instr_i(instr_i), .rd_we_i(rd_we_i), .rd_addr_i(rd_addr_i),
        .rd_data_i(rd_data_i), .stall_o(stall_o), .valid_o(valid_o), .pc_o(pc_o),
        .instr_o(instr_o), .rs1_data_o(rs1_data_o), .rs2_data_o(rs2_data_o), .imm_o(imm_o),
        .op_o(op_o), .rd_addr_o(rd_addr_o), .rf_we_o(rf_we_o), .mem_we_o(mem_we_o)
    );

    always #50 clk_i = ~clk_i;                     // 100 ns period.

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Bit placement of the S, B and J formats.
    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    task automatic step();
        @(posedge clk_i);
        #10;                                       // Drive and sample away from the edge.
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        tests_run++;
        if (errors == first_err) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - first_err);
            tests_failed++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (stall_o && n < TIMEOUT) begin
            step();
            n++;
        end
        if (stall_o) begin
            $display("Timeout: stall_o stayed high for %0d cycles", TIMEOUT);
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        rd_we_i   = 1'b1;
        rd_addr_i = addr;
        rd_data_i = data;
        step();
        rd_we_i = 1'b0;
        if (addr != 5'd0) model_regs[addr] = data;  // x0 keeps zero.
    endtask

    task automatic check_bundle(input logic [31:0] word, input logic [31:0] pc,
                                input operation_e exp_op, input logic [31:0] exp_imm,
                                input logic [31:0] exp_rs1, input logic [31:0] exp_rs2,
                                input logic exp_rf_we, input logic exp_mem_we);
        check("valid_o", 32'(valid_o), 1);
        check("pc_o", pc_o, pc);
        check("instr_o", instr_o, word);
        check("rd_addr_o", 32'(rd_addr_o), 32'(word[11:7]));
        check("op_o", 32'(op_o), 32'(exp_op));
        check("imm_o", imm_o, exp_imm);
        check("rs1_data_o", rs1_data_o, exp_rs1);
        check("rs2_data_o", rs2_data_o, exp_rs2);
        check("rf_we_o", 32'(rf_we_o), 32'(exp_rf_we));
        check("mem_we_o", 32'(mem_we_o), 32'(exp_mem_we));
    endtask

    // Issues one word, checks the bundle and can hand the credit straight back.
    task automatic issue_check(input logic [31:0] word, input operation_e exp_op,
                               input logic [31:0] exp_imm, input logic [31:0] exp_rs1,
                               input logic [31:0] exp_rs2, input logic exp_rf_we,
                               input logic exp_mem_we, input logic ret_credit);
        wait_ready();
        instr_valid_i = 1'b1;
        instr_i       = word;
        pc_i          = pc_next;
        step();
        instr_valid_i = 1'b0;
        check_bundle(word, pc_next, exp_op, exp_imm, exp_rs1, exp_rs2, exp_rf_we, exp_mem_we);
        pc_next += 4;
        if (ret_credit) begin
            credit_i = 1'b1;                       // Execute frees the entry at once.
            step();
            credit_i = 1'b0;
            check("valid_o", 32'(valid_o), 0);
        end
    endtask

    task automatic test_reset();
        int first_err;
        first_err = errors;
        check("valid_o", 32'(valid_o), 0);
        check("rf_we_o", 32'(rf_we_o), 0);
        check("mem_we_o", 32'(mem_we_o), 0);
        check("stall_o", 32'(stall_o), 0);
        issue_check({`F7_ADD, 5'd2, 5'd1, `F3_ADD_SUB, 5'd3, `OPC_OP}, ADD, 0, 0, 0,
                    1'b1, 1'b0, 1'b1);
        report_test("reset", first_err);
    endtask

    task automatic test_regs();
        int first_err;
        logic [4:0] rs1, rs2, rd;
        logic [11:0] imm;
        operation_e ops [10] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND};
        logic [2:0] f3s [10] = '{`F3_ADD_SUB, `F3_ADD_SUB, `F3_SLL, `F3_SLT, `F3_SLTU,
                                 `F3_XOR, `F3_SRL_SRA, `F3_SRL_SRA, `F3_OR, `F3_AND};
        logic [6:0] f7s [10] = '{`F7_ADD, `F7_SUB, 7'd0, 7'd0, 7'd0, 7'd0, `F7_SRL, `F7_SRA,
                                 7'd0, 7'd0};
        operation_e iops [6] = '{ADDI, SLTI, SLTIU, XORI, ORI, ANDI};
        logic [2:0] if3s [6] = '{`F3_ADD_SUB, `F3_SLT, `F3_SLTU, `F3_XOR, `F3_OR, `F3_AND};
        first_err = errors;
        for (int k = 0; k < 7; k++) begin
            write_reg(5'(k), next_random());       // The write to x0 must be dropped.
        end
        for (int k = 0; k < 10; k++) begin
            rs1 = 5'(next_random() % 7);
            rs2 = 5'(next_random() % 7);
            rd  = 5'(next_random());
            issue_check({f7s[k], rs2, rs1, f3s[k], rd, `OPC_OP}, ops[k], 0, model_regs[rs1],
                        model_regs[rs2], 1'b1, 1'b0, 1'b1);
        end
        for (int k = 0; k < 6; k++) begin
            rs1 = 5'(next_random() % 7);
            imm = 12'(next_random());
            issue_check({imm, rs1, if3s[k], 5'd7, `OPC_OP_IMM}, iops[k], {{20{imm[11]}}, imm},
                        model_regs[rs1], 0, 1'b1, 1'b0, 1'b1);
        end
        issue_check({`F7_ADD, 5'd0, 5'd0, `F3_ADD_SUB, 5'd8, `OPC_OP}, ADD, 0, 0, 0,
                    1'b1, 1'b0, 1'b1);            // x0 on both sources reads zero.
        report_test("register read", first_err);
    endtask

    task automatic test_imm_formats();
        int first_err;
        logic [31:0] r;
        logic [4:0]  rd, rs1, rs2;
        logic [20:0] jimm;
        logic [12:0] bimm;
        first_err = errors;
        rd  = 5'(next_random());
        rs1 = 5'(next_random() % 6 + 1);
        rs2 = 5'(next_random() % 6 + 1);
        r = next_random();
        r[24:15] = {rs2, rs1};                     // Unused source fields name written registers.
        issue_check({r[31:12], rd, `OPC_LUI}, LUI, {r[31:12], 12'd0}, 0, 0, 1'b1, 1'b0, 1'b1);
        r = next_random();
        r[24:15] = {rs2, rs1};
        issue_check({r[31:12], rd, `OPC_AUIPC}, AUIPC, {r[31:12], 12'd0}, 0, 0,
                    1'b1, 1'b0, 1'b1);
        r = next_random();
        jimm = {r[20:1], 1'b0};
        jimm[19:15] = rs1;                         // Word bits 19:15 hold imm[19:15].
        {jimm[4:1], jimm[11]} = rs2;               // Word bits 24:20 hold imm[4:1] and imm[11].
        issue_check(enc_j(jimm, rd), JAL, {{11{jimm[20]}}, jimm}, 0, 0, 1'b1, 1'b0, 1'b1);
        r = next_random();
        r[4:0] = rs2;                              // The rs2 field sits in the low immediate bits.
        issue_check({r[11:0], rs1, `F3_JALR, rd, `OPC_JALR}, JALR, {{20{r[11]}}, r[11:0]},
                    model_regs[rs1], 0, 1'b1, 1'b0, 1'b1);
        r = next_random();
        bimm = {r[12:1], 1'b0};
        issue_check(enc_b(bimm, rs2, rs1, `F3_BNE), BNE, {{19{bimm[12]}}, bimm},
                    model_regs[rs1], model_regs[rs2], 1'b0, 1'b0, 1'b1);
        r = next_random();
        r[4:0] = rs2;
        issue_check({r[11:0], rs1, `F3_LW, rd, `OPC_LOAD}, LW, {{20{r[11]}}, r[11:0]},
                    model_regs[rs1], 0, 1'b1, 1'b0, 1'b1);
        r = next_random();
        issue_check(enc_s(r[11:0], rs2, rs1, `F3_SW), SW, {{20{r[11]}}, r[11:0]},
                    model_regs[rs1], model_regs[rs2], 1'b0, 1'b1, 1'b1);
        r = next_random();
        r[4:0] = rs2;
        issue_check({`F7_SLLI, r[4:0], rs1, `F3_SLL, rd, `OPC_OP_IMM}, SLLI, {27'd0, r[4:0]},
                    model_regs[rs1], 0, 1'b1, 1'b0, 1'b1);  // Shamt sits in the rs2 field.
        report_test("immediate formats", first_err);
    endtask

    task automatic test_unknown();
        int first_err;
        logic [31:0] r;
        first_err = errors;
        r = next_random();
        issue_check({r[31:7], 7'b1111111}, UNKNOWN, 0, 0, 0, 1'b0, 1'b0, 1'b1);
        issue_check({r[31:20], 5'd1, 3'b011, 5'd4, `OPC_LOAD}, UNKNOWN, 0, 0, 0,
                    1'b0, 1'b0, 1'b1);
        issue_check({7'b0000001, 5'd2, 5'd1, `F3_ADD_SUB, 5'd4, `OPC_OP}, UNKNOWN, 0, 0, 0,
                    1'b0, 1'b0, 1'b1);
        issue_check({7'b0000001, r[4:0], 5'd1, `F3_SRL_SRA, 5'd4, `OPC_OP_IMM}, UNKNOWN, 0,
                    0, 0, 1'b0, 1'b0, 1'b1);
        report_test("unknown decode", first_err);
    endtask

    task automatic test_credits();
        int first_err;
        logic [11:0] imm;
        logic [31:0] word;
        first_err = errors;
        for (int k = 0; k < `DEC_CREDITS; k++) begin
            issue_check({`F7_ADD, 5'd2, 5'd1, `F3_ADD_SUB, 5'd3, `OPC_OP}, ADD, 0,
                        model_regs[1], model_regs[2], 1'b1, 1'b0, 1'b0);
        end
        check("stall_o", 32'(stall_o), 1);
        imm  = 12'(next_random());
        word = {imm, 5'd2, `F3_ADD_SUB, 5'd4, `OPC_OP_IMM};
        instr_valid_i = 1'b1;                      // Fetch holds this word while stalled.
        instr_i       = word;
        pc_i          = pc_next;
        step();
        check("valid_o", 32'(valid_o), 0);
        check("stall_o", 32'(stall_o), 1);
        credit_i = 1'b1;
        step();
        credit_i = 1'b0;
        check("stall_o", 32'(stall_o), 0);
        check("valid_o", 32'(valid_o), 0);
        step();
        instr_valid_i = 1'b0;
        check_bundle(word, pc_next, ADDI, {{20{imm[11]}}, imm}, model_regs[2], 0, 1'b1, 1'b0);
        pc_next += 4;
        credit_i = 1'b1;                           // Execute drains every entry it holds.
        repeat (`DEC_CREDITS) step();
        credit_i = 1'b0;
        check("stall_o", 32'(stall_o), 0);
        report_test("credit back-pressure", first_err);
    endtask

    initial begin
        clk_i = 1'b0;
        rstn_i = 1'b0;
        instr_valid_i = 1'b0;
        credit_i = 1'b0;
        pc_i = '0;
        instr_i = '0;
        rd_we_i = 1'b0;
        rd_addr_i = '0;
        rd_data_i = '0;
        rng = 32'hfeff5438;
        pc_next = 32'h0000_1000;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int k = 0; k < `REG_COUNT; k++) model_regs[k] = '0;
        repeat (2) @(posedge clk_i);
        #10;
        rstn_i = 1'b1;
        test_reset();
        test_regs();
        test_imm_formats();
        test_unknown();
        test_credits();
        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   instr_valid_i,  // Instruction present from fetch.
    input  logic                   credit_i,       // Credit return from execute.
    input  logic [`XLEN-1:0]       pc_i,
    input  instr_u                 instr_i,
    input  logic                   rd_we_i,        // Write-back port.
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`XLEN-1:0]       rd_data_i,
    output logic                   stall_o,
    output logic                   valid_o,
    output logic [`XLEN-1:0]       pc_o,
    output logic [`XLEN-1:0]       instr_o,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    output logic [`XLEN-1:0]       imm_o,
    output operation_e             op_o,
    output logic [`REG_ADDR_W-1:0] rd_addr_o,
    output logic                   rf_we_o,
    output logic                   mem_we_o
);

    logic [`XLEN-1:0] rs1_data;                    // Raw register reads before masking.
    logic [`XLEN-1:0] rs2_data;

    decode_if dec_bus ();                          // Decoder to issue stage control.

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .dec     (dec_bus.decoder)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .instr_i    (instr_i),
        .rd_we_i    (rd_we_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_i  (rd_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    issue_stage u_issue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .credit_i      (credit_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .dec           (dec_bus.issue),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .stall_o       (stall_o),
        .valid_o       (valid_o),
        .pc_o          (pc_o),
        .instr_o       (instr_o),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .imm_o         (imm_o),
        .op_o          (op_o),
        .rd_addr_o     (rd_addr_o),
        .rf_we_o       (rf_we_o),
        .mem_we_o      (mem_we_o)
    );

endmodule

// File: issue_stage.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module issue_stage
    import decode_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   instr_valid_i,  // Fetch presents an instruction.
    input  logic                   credit_i,       // Execute frees one entry.
    input  logic [`XLEN-1:0]       pc_i,
    input  instr_u                 instr_i,
    decode_if.issue                dec,            // Control from the decoder.
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    output logic                   stall_o,        // No credit left so fetch must hold.
    output logic                   valid_o,        // Bundle issued on the last edge.
    output logic [`XLEN-1:0]       pc_o,
    output logic [`XLEN-1:0]       instr_o,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    output logic [`XLEN-1:0]       imm_o,
    output operation_e             op_o,
    output logic [`REG_ADDR_W-1:0] rd_addr_o,
    output logic                   rf_we_o,
    output logic                   mem_we_o
);

    localparam int CNT_W = $clog2(`DEC_CREDITS + 1);  // Wide enough to hold the full count.

    logic [CNT_W-1:0] credits;                     // Free entries downstream.
    logic             issue;                       // An instruction leaves on this edge.

    assign stall_o = (credits == '0);
    assign issue   = instr_valid_i && !stall_o;    // Valid is ignored while stalled.

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            credits <= CNT_W'(`DEC_CREDITS);
        end else if (issue && !credit_i) begin
            credits <= credits - 1'b1;
        end else if (credit_i && !issue) begin
            credits <= credits + 1'b1;             // Execute never returns more than it took.
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o    <= 1'b0;
            rf_we_o    <= 1'b0;
            mem_we_o   <= 1'b0;
            pc_o       <= '0;
            instr_o    <= '0;
            rs1_data_o <= '0;
            rs2_data_o <= '0;
            imm_o      <= '0;
            op_o       <= UNKNOWN;
            rd_addr_o  <= '0;
        end else begin
            valid_o  <= issue;
            rf_we_o  <= issue && dec.rf_we;        // Enables last only as long as valid_o.
            mem_we_o <= issue && dec.mem_we;
            if (issue) begin
                pc_o       <= pc_i;
                instr_o    <= instr_i;
                rs1_data_o <= dec.use_rs1 ? rs1_data_i : '0;  // Unused operands go out as zero.
                rs2_data_o <= dec.use_rs2 ? rs2_data_i : '0;
                imm_o      <= dec.imm;
                op_o       <= dec.op;
                rd_addr_o  <= instr_i.r.rd;
            end
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module reg_file
    import decode_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  instr_u                 instr_i,        // Source addresses come from the R view.
    input  logic                   rd_we_i,        // Write-back enable.
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,      // Write-back address.
    input  logic [`XLEN-1:0]       rd_data_i,      // Write-back data.
    output logic [`XLEN-1:0]       rs1_data_o,     // First source operand.
    output logic [`XLEN-1:0]       rs2_data_o      // Second source operand.
);

    logic [`XLEN-1:0] regs [`REG_COUNT];           // The architectural registers.

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int k = 0; k < `REG_COUNT; k++) begin
                regs[k] <= '0;                     // Every register starts at zero.
            end
        end else if (rd_we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;          // x0 is never written and so reads zero.
        end
    end

    // Reads see the value from before a write in the same cycle.
    assign rs1_data_o = regs[instr_i.r.rs1];
    assign rs2_data_o = regs[instr_i.r.rs2];

endmodule

// File: instr_decoder.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

module instr_decoder
    import decode_pkg::*;
(
    input  instr_u     instr_i,                    // Instruction word from fetch.
    decode_if.decoder  dec                         // Decoded control toward the issue stage.
);

    operation_e       op;                          // Operation picked from opcode, funct3 and funct7.
    logic [`XLEN-1:0] imm_i;                       // I-format immediate, sign-extended.
    logic [`XLEN-1:0] imm_s;                       // S-format immediate, sign-extended.
    logic [`XLEN-1:0] imm_b;                       // B-format offset, sign-extended.
    logic [`XLEN-1:0] imm_u;                       // U-format upper immediate.
    logic [`XLEN-1:0] imm_j;                       // J-format offset, sign-extended.
    logic [`XLEN-1:0] imm_sh;                      // Shift amount, zero-extended.

    assign imm_i  = {{20{instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
    assign imm_s  = {{20{instr_i.s.imm11_5[6]}}, instr_i.s.imm11_5, instr_i.s.imm4_0};
    assign imm_b  = {{20{instr_i.b.imm12}}, instr_i.b.imm11, instr_i.b.imm10_5,
                     instr_i.b.imm4_1, 1'b0};      // Branch offsets are even.
    assign imm_u  = {instr_i.u.imm31_12, 12'b0};
    assign imm_j  = {{12{instr_i.j.imm20}}, instr_i.j.imm19_12, instr_i.j.imm11,
                     instr_i.j.imm10_1, 1'b0};
    assign imm_sh = {{(`XLEN-`REG_ADDR_W){1'b0}}, instr_i.r.rs2};

    always_comb begin
        op = UNKNOWN;                              // Anything not matched below stays UNKNOWN.
        case (instr_i.r.opcode)
            `OPC_LUI:   op = LUI;
            `OPC_AUIPC: op = AUIPC;
            `OPC_JAL:   op = JAL;
            `OPC_JALR:
                if (instr_i.i.funct3 == `F3_JALR) op = JALR;
            `OPC_BRANCH:
                case (instr_i.b.funct3)
                    `F3_BEQ:  op = BEQ;
                    `F3_BNE:  op = BNE;
                    `F3_BLT:  op = BLT;
                    `F3_BGE:  op = BGE;
                    `F3_BLTU: op = BLTU;
                    `F3_BGEU: op = BGEU;
                    default:  op = UNKNOWN;        // Codes 2 and 3 are not branches.
                endcase
            `OPC_LOAD:
                case (instr_i.i.funct3)
                    `F3_LB:  op = LB;
                    `F3_LH:  op = LH;
                    `F3_LW:  op = LW;
                    `F3_LBU: op = LBU;
                    `F3_LHU: op = LHU;
                    default: op = UNKNOWN;
                endcase
            `OPC_STORE:
                case (instr_i.s.funct3)
                    `F3_SB:  op = SB;
                    `F3_SH:  op = SH;
                    `F3_SW:  op = SW;
                    default: op = UNKNOWN;
                endcase
            `OPC_OP_IMM:
                case (instr_i.i.funct3)
                    `F3_ADD_SUB: op = ADDI;
                    `F3_SLT:     op = SLTI;
                    `F3_SLTU:    op = SLTIU;
                    `F3_XOR:     op = XORI;
                    `F3_OR:      op = ORI;
                    `F3_AND:     op = ANDI;
                    `F3_SLL:
                        if (instr_i.r.funct7 == `F7_SLLI) op = SLLI;
                    `F3_SRL_SRA:
                        if (instr_i.r.funct7 == `F7_SRLI) begin
                            op = SRLI;
                        end else if (instr_i.r.funct7 == `F7_SRAI) begin
                            op = SRAI;             // Only funct7 separates the two right shifts.
                        end
                    default:     op = UNKNOWN;
                endcase
            `OPC_OP:
                case (instr_i.r.funct3)
                    `F3_ADD_SUB:
                        if (instr_i.r.funct7 == `F7_ADD) begin
                            op = ADD;
                        end else if (instr_i.r.funct7 == `F7_SUB) begin
                            op = SUB;
                        end
                    `F3_SLL:  op = SLL;            // funct7 is not checked for this group.
                    `F3_SLT:  op = SLT;
                    `F3_SLTU: op = SLTU;
                    `F3_XOR:  op = XOR;
                    `F3_OR:   op = OR;
                    `F3_AND:  op = AND;
                    `F3_SRL_SRA:
                        if (instr_i.r.funct7 == `F7_SRL) begin
                            op = SRL;
                        end else if (instr_i.r.funct7 == `F7_SRA) begin
                            op = SRA;
                        end
                    default:  op = UNKNOWN;
                endcase
            default:    op = UNKNOWN;
        endcase
    end

    assign dec.op = op;

    // The format of each operation fixes its immediate, enables and operand use.
    always_comb begin
        dec.imm     = '0;                          // UNKNOWN leaves all of these low.
        dec.rf_we   = 1'b0;
        dec.mem_we  = 1'b0;
        dec.use_rs1 = 1'b0;
        dec.use_rs2 = 1'b0;
        case (op)
            LUI, AUIPC: begin
                dec.imm   = imm_u;
                dec.rf_we = 1'b1;
            end
            JAL: begin
                dec.imm   = imm_j;
                dec.rf_we = 1'b1;                  // Link address goes to rd.
            end
            JALR, LB, LH, LW, LBU, LHU, ADDI, SLTI, SLTIU, XORI, ORI, ANDI: begin
                dec.imm     = imm_i;
                dec.rf_we   = 1'b1;
                dec.use_rs1 = 1'b1;
            end
            SLLI, SRLI, SRAI: begin
                dec.imm     = imm_sh;              // The shift amount travels as the immediate.
                dec.rf_we   = 1'b1;
                dec.use_rs1 = 1'b1;
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                dec.imm     = imm_b;
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
            end
            SB, SH, SW: begin
                dec.imm     = imm_s;
                dec.mem_we  = 1'b1;
                dec.use_rs1 = 1'b1;                // Base address.
                dec.use_rs2 = 1'b1;                // Store data.
            end
            ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND: begin
                dec.rf_we   = 1'b1;
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: decode_if.sv
`timescale 1ns/100ps
`include "decode_macros.svh"

interface decode_if
    import decode_pkg::*;
();

    operation_e         op;                        // Classified operation.
    logic [`XLEN-1:0]   imm;                       // Extended immediate or shift amount.
    logic               rf_we;                     // Instruction writes a register.
    logic               mem_we;                    // Instruction writes memory.
    logic               use_rs1;                   // First source register is read.
    logic               use_rs2;                   // Second source register is read.

    modport decoder (
        output op, imm, rf_we, mem_we, use_rs1, use_rs2
    );

    modport issue (
        input  op, imm, rf_we, mem_we, use_rs1, use_rs2
    );

endinterface

// File: decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    typedef enum logic [5:0] {
        UNKNOWN,                                   // Zero value so a cleared bundle reads UNKNOWN.
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } operation_e;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;              // Also the shift amount of immediate shifts.
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm11_0;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm4_0;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;            // Bit 11 sits where the rd field would be.
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;                                 // The opcode is read through this view.
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

// File: decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define XLEN        32               // Data word width.
`define REG_COUNT   32               // Number of architectural registers.
`define REG_ADDR_W  5                // Register address width.
`define DEC_CREDITS 2                // Entries the execute stage can hold.

`define OPC_LUI     7'b0110111       // Load upper immediate.
`define OPC_AUIPC   7'b0010111       // Add upper immediate to PC.
`define OPC_JAL     7'b1101111       // Jump and link.
`define OPC_JALR    7'b1100111       // Jump and link register.
`define OPC_BRANCH  7'b1100011       // Conditional branches.
`define OPC_LOAD    7'b0000011       // Loads.
`define OPC_STORE   7'b0100011       // Stores.
`define OPC_OP_IMM  7'b0010011       // Register-immediate ALU group.
`define OPC_OP      7'b0110011       // Register-register ALU group.

`define F3_JALR     3'b000
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111
`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101
`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010
`define F3_ADD_SUB  3'b000           // Shared by ADD, SUB and ADDI.
`define F3_SLL      3'b001           // Shared by SLL and SLLI.
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101           // Right shifts are told apart by funct7.
`define F3_OR       3'b110
`define F3_AND      3'b111

`define F7_ADD      7'b0000000
`define F7_SUB      7'b0100000
`define F7_SLLI     7'b0000000
`define F7_SRLI     7'b0000000
`define F7_SRAI     7'b0100000
`define F7_SRL      7'b0000000
`define F7_SRA      7'b0100000

`endif
